//--- source/csr_config.svh
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

`define CSR_ENTRY_POINT 32'h0000_0010 // mtvec after reset, four words in
`define CSR_RETIRE_WIDTH 2

// fields of the 12-bit csr address
`define CSR_RO_FIELD 11:10
`define CSR_PRIV_FIELD 9:8

`define CSR_MSTATUS 12'h300
`define CSR_MIE 12'h304
`define CSR_MTVEC 12'h305
`define CSR_MCOUNTEREN 12'h306
`define CSR_MCOUNTINHIBIT 12'h320
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC 12'h341
`define CSR_MCAUSE 12'h342
`define CSR_MTVAL 12'h343
`define CSR_MIP 12'h344
`define CSR_MCYCLE 12'hB00
`define CSR_MINSTRET 12'hB02
`define CSR_MCYCLEH 12'hB80
`define CSR_MINSTRETH 12'hB82
// user mirrors, read only
`define CSR_CYCLE 12'hC00
`define CSR_INSTRET 12'hC02
`define CSR_CYCLEH 12'hC80
`define CSR_INSTRETH 12'hC82
`define CSR_MHARTID 12'hF14

`endif

//--- source/csrPkg.sv
package csrPkg;

    typedef logic [31:0] CsrData;
    typedef logic [11:0] CsrAddr;
    typedef logic [63:0] CounterVal;
    typedef logic [3:0] TrapCause;
    typedef logic [30:0] CodeAddr; // pc without bit 0

    // encodings follow the privileged spec
    typedef enum logic [1:0] {
        PrivUser = 2'b00,
        PrivMachine = 2'b11
    } PrivLevel;

    typedef enum logic [2:0] {
        OpRead,
        OpWrite,
        OpSet,
        OpClear,
        OpWriteImm,
        OpSetImm,
        OpClearImm,
        OpMret
    } CsrOp;

    typedef enum logic [1:0] {
        FlagNone,
        FlagIllegal,
        FlagXret
    } ResultFlag;

    // bit index in mip/mie and interrupt cause code
    typedef enum logic [3:0] {
        IrqMsi = 4'd3,
        IrqMti = 4'd7,
        IrqMei = 4'd11
    } IrqCause;

endpackage

//--- source/csrControl.sv
`timescale 1ns/1ps
`include "csr_config.svh"

module csrControl import csrPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      reqValid,
    input  CsrOp      reqOp,
    input  CsrAddr    reqAddr,
    input  CsrData    reqSrc,
    input  logic [4:0] reqImm,
    input  logic      reqReadDst,
    input  PrivLevel  priv,
    input  logic      userCountOk,
    input  CsrData    trapRegsRdata,
    input  logic      trapRegsHit,
    input  CsrData    counterRdata,
    input  logic      counterHit,
    input  CsrData    irqRdata,
    input  logic      irqHit,
    output logic      writeEn,
    output CsrAddr    writeAddr,
    output CsrData    writeData,
    output logic      mretEn,
    output logic      resultValid,
    output CsrData    result,
    output ResultFlag resultFlag
);

    CsrData readData;
    CsrData operand;
    logic [1:0] privBits;
    logic isMret;
    logic isImm;
    logic known;
    logic writeIntent;
    logic illegal;
    ResultFlag flagNext;

    // mhartid hits nowhere and reads as zero
    always_comb begin
        if (trapRegsHit)
            readData = trapRegsRdata;
        else if (counterHit)
            readData = counterRdata;
        else if (irqHit)
            readData = irqRdata;
        else
            readData = '0;
    end

    assign known = trapRegsHit || counterHit || irqHit || (reqAddr == `CSR_MHARTID);
    assign privBits = priv;
    assign isMret = (reqOp == OpMret);
    assign isImm = (reqOp == OpWriteImm) || (reqOp == OpSetImm) || (reqOp == OpClearImm);
    assign operand = isImm ? {27'b0, reqImm} : reqSrc;

    always_comb begin
        case (reqOp)
            OpWrite, OpWriteImm: begin
                writeData = operand;
                writeIntent = 1'b1;
            end
            OpSet, OpSetImm: begin
                writeData = readData | operand;
                writeIntent = (operand != '0); // zero mask leaves csr alone
            end
            OpClear, OpClearImm: begin
                writeData = readData & ~operand;
                writeIntent = (operand != '0);
            end
            default: begin
                writeData = readData;
                writeIntent = 1'b0;
            end
        endcase
    end

    always_comb begin
        if (isMret)
            illegal = (priv == PrivUser);
        else
            illegal = !known
                || (privBits < reqAddr[`CSR_PRIV_FIELD])
                || (priv == PrivUser && !userCountOk)
                || (writeIntent && reqAddr[`CSR_RO_FIELD] == 2'b11);
    end

    assign writeEn = reqValid && !isMret && !illegal && writeIntent;
    assign writeAddr = reqAddr;
    assign mretEn = reqValid && isMret && !illegal;
    assign flagNext = illegal ? FlagIllegal : (isMret ? FlagXret : FlagNone);

    always_ff @(posedge clk) begin
        if (rst)
            resultValid <= 1'b0;
        else
            resultValid <= reqValid;
    end

    always_ff @(posedge clk) begin
        if (reqValid) begin
            resultFlag <= flagNext;
            result <= (reqReadDst && !illegal && !isMret) ? readData : '0;
        end
    end

    // a committed write must come back as a legal result
    assert property (@(posedge clk) disable iff (rst)
        writeEn |=> resultValid && resultFlag != FlagIllegal);

endmodule

//--- source/machineTrapRegs.sv
`timescale 1ns/1ps
`include "csr_config.svh"

module machineTrapRegs import csrPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  CsrAddr   reqAddr,
    input  logic     writeEn,
    input  CsrAddr   writeAddr,
    input  CsrData   writeData,
    input  logic     mretEn,
    input  logic     trapValid,
    input  CodeAddr  trapPc,
    input  TrapCause trapCause,
    input  logic     trapIsIrq,
    input  CsrData   trapVal,
    output CsrData   rdata,
    output logic     hit,
    output PrivLevel priv,
    output logic     mstatusMie,
    output CsrData   mie,
    output CodeAddr  retVec,
    output CodeAddr  trapVec
);

    logic mstatusMpie;
    PrivLevel mstatusMpp;
    CsrData mstatusWord;
    logic [29:0] mtvecBase; // direct mode only
    CodeAddr mepc;
    logic mcauseIrq;
    TrapCause mcauseCode;
    CsrData mtval;
    CsrData mscratch;
    logic mieMsi;
    logic mieMti;
    logic mieMei;

    always_comb begin
        mstatusWord = '0;
        mstatusWord[3] = mstatusMie;
        mstatusWord[7] = mstatusMpie;
        mstatusWord[12:11] = mstatusMpp;
    end

    assign mie = {20'b0, mieMei, 3'b0, mieMti, 3'b0, mieMsi, 3'b0};
    assign trapVec = {mtvecBase, 1'b0};

    always_comb begin
        hit = 1'b1;
        rdata = '0;
        case (reqAddr)
            `CSR_MSTATUS: rdata = mstatusWord;
            `CSR_MTVEC: rdata = {mtvecBase, 2'b00};
            `CSR_MEPC: rdata = {mepc, 1'b0};
            `CSR_MCAUSE: rdata = {mcauseIrq, 27'b0, mcauseCode};
            `CSR_MTVAL: rdata = mtval;
            `CSR_MSCRATCH: rdata = mscratch;
            `CSR_MIE: rdata = mie;
            default: hit = 1'b0;
        endcase
    end

    // trap beats mret beats software write
    always_ff @(posedge clk) begin
        if (rst) begin
            priv <= PrivMachine;
            mstatusMie <= 1'b0;
            mstatusMpie <= 1'b0;
            mstatusMpp <= PrivUser;
            mtvecBase <= 30'(`CSR_ENTRY_POINT >> 2);
            mieMsi <= 1'b0;
            mieMti <= 1'b0;
            mieMei <= 1'b0;
        end else if (trapValid) begin
            mstatusMpie <= mstatusMie;
            mstatusMie <= 1'b0;
            mstatusMpp <= priv;
            priv <= PrivMachine;
        end else if (mretEn) begin
            mstatusMie <= mstatusMpie;
            mstatusMpie <= 1'b1;
            mstatusMpp <= PrivUser;
            priv <= mstatusMpp;
        end else if (writeEn) begin
            case (writeAddr)
                `CSR_MSTATUS: begin
                    mstatusMie <= writeData[3];
                    mstatusMpie <= writeData[7];
                    // warl, unsupported modes fall back to user
                    mstatusMpp <= (writeData[12:11] == 2'b11) ? PrivMachine : PrivUser;
                end
                `CSR_MTVEC: mtvecBase <= writeData[31:2];
                `CSR_MIE: begin
                    mieMsi <= writeData[3];
                    mieMti <= writeData[7];
                    mieMei <= writeData[11];
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (trapValid) begin
            mepc <= trapPc;
            mcauseIrq <= trapIsIrq;
            mcauseCode <= trapCause;
            mtval <= trapVal;
        end else if (writeEn) begin
            case (writeAddr)
                `CSR_MEPC: mepc <= writeData[31:1];
                `CSR_MCAUSE: begin
                    mcauseIrq <= writeData[31];
                    mcauseCode <= writeData[3:0];
                end
                `CSR_MTVAL: mtval <= writeData;
                `CSR_MSCRATCH: mscratch <= writeData;
                default: ;
            endcase
        end
        if (mretEn && !trapValid)
            retVec <= mepc;
    end

    // priv is reloaded from mpp, which software writes
    assert property (@(posedge clk) disable iff (rst)
        priv == PrivUser || priv == PrivMachine);

endmodule

//--- source/perfCounters.sv
`timescale 1ns/1ps
`include "csr_config.svh"

module perfCounters import csrPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  CsrAddr reqAddr,
    input  logic   writeEn,
    input  CsrAddr writeAddr,
    input  CsrData writeData,
    input  logic [$clog2(`CSR_RETIRE_WIDTH + 1) - 1:0] retireCount,
    output CsrData rdata,
    output logic   hit,
    output logic   userCountOk
);

    CounterVal mcycle;
    CounterVal minstret;
    logic inhibitCycle;
    logic inhibitInstret;
    logic enCycle; // mcounteren bit 0
    logic enInstret; // mcounteren bit 2

    always_comb begin
        hit = 1'b1;
        rdata = '0;
        case (reqAddr)
            `CSR_MCYCLE, `CSR_CYCLE: rdata = mcycle[31:0];
            `CSR_MCYCLEH, `CSR_CYCLEH: rdata = mcycle[63:32];
            `CSR_MINSTRET, `CSR_INSTRET: rdata = minstret[31:0];
            `CSR_MINSTRETH, `CSR_INSTRETH: rdata = minstret[63:32];
            `CSR_MCOUNTINHIBIT: rdata = {29'b0, inhibitInstret, 1'b0, inhibitCycle};
            `CSR_MCOUNTEREN: rdata = {29'b0, enInstret, 1'b0, enCycle};
            default: hit = 1'b0;
        endcase
    end

    always_comb begin
        case (reqAddr)
            `CSR_CYCLE, `CSR_CYCLEH: userCountOk = enCycle;
            `CSR_INSTRET, `CSR_INSTRETH: userCountOk = enInstret;
            default: userCountOk = 1'b1;
        endcase
    end

    // a software write to one half overrides that half's increment
    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle <= '0;
            minstret <= '0;
            inhibitCycle <= 1'b0;
            inhibitInstret <= 1'b0;
            enCycle <= 1'b0;
            enInstret <= 1'b0;
        end else begin
            if (!inhibitCycle)
                mcycle <= mcycle + 64'd1;
            if (!inhibitInstret)
                minstret <= minstret + CounterVal'(retireCount);
            if (writeEn) begin
                case (writeAddr)
                    `CSR_MCYCLE: mcycle[31:0] <= writeData;
                    `CSR_MCYCLEH: mcycle[63:32] <= writeData;
                    `CSR_MINSTRET: minstret[31:0] <= writeData;
                    `CSR_MINSTRETH: minstret[63:32] <= writeData;
                    `CSR_MCOUNTINHIBIT: begin
                        inhibitCycle <= writeData[0];
                        inhibitInstret <= writeData[2];
                    end
                    `CSR_MCOUNTEREN: begin
                        enCycle <= writeData[0];
                        enInstret <= writeData[2];
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- source/interruptArbiter.sv
`timescale 1ns/1ps
`include "csr_config.svh"

module interruptArbiter import csrPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  CsrAddr    reqAddr,
    input  logic      writeEn,
    input  CsrAddr    writeAddr,
    input  CsrData    writeData,
    input  logic      irq,
    input  CounterVal mtime,
    input  CounterVal mtimecmp,
    input  CsrData    mie,
    input  logic      mstatusMie,
    input  PrivLevel  priv,
    output CsrData    rdata,
    output logic      hit,
    output logic      irqPending,
    output IrqCause   irqCause
);

    logic mipMsi;
    logic mipMti;
    logic mipMei;
    logic msiReady;
    logic mtiReady;
    logic meiReady;
    logic globalEn;

    always_ff @(posedge clk) begin
        if (rst) begin
            mipMsi <= 1'b0;
            mipMti <= 1'b0;
            mipMei <= 1'b0;
        end else begin
            mipMti <= (mtime >= mtimecmp);
            mipMei <= irq;
            if (writeEn && writeAddr == `CSR_MIP)
                mipMsi <= writeData[3]; // only msip is writable
        end
    end

    assign hit = (reqAddr == `CSR_MIP);
    assign rdata = {20'b0, mipMei, 3'b0, mipMti, 3'b0, mipMsi, 3'b0};

    assign msiReady = mipMsi && mie[IrqMsi];
    assign mtiReady = mipMti && mie[IrqMti];
    assign meiReady = mipMei && mie[IrqMei];
    assign globalEn = (priv == PrivUser) || mstatusMie; // user mode is always interruptible

    always_comb begin
        if (meiReady)
            irqCause = IrqMei;
        else if (msiReady)
            irqCause = IrqMsi;
        else if (mtiReady)
            irqCause = IrqMti;
        else
            irqCause = IrqMei;
    end

    assign irqPending = globalEn && (meiReady || msiReady || mtiReady);

    assert property (@(posedge clk) disable iff (rst)
        irqPending |-> (irqCause inside {IrqMsi, IrqMti, IrqMei}) && mie[irqCause]);

endmodule

//--- source/csrUnit.sv
`timescale 1ns/1ps
`include "csr_config.svh"

module csrUnit import csrPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      reqValid,
    input  CsrOp      reqOp,
    input  CsrAddr    reqAddr,
    input  CsrData    reqSrc,
    input  logic [4:0] reqImm,
    input  logic      reqReadDst,
    input  logic      trapValid,
    input  CodeAddr   trapPc,
    input  TrapCause  trapCause,
    input  logic      trapIsIrq,
    input  CsrData    trapVal,
    input  logic      irq,
    input  CounterVal mtime,
    input  CounterVal mtimecmp,
    input  logic [$clog2(`CSR_RETIRE_WIDTH + 1) - 1:0] retireCount,
    output logic      resultValid,
    output CsrData    result,
    output ResultFlag resultFlag,
    output CodeAddr   retVec,
    output CodeAddr   trapVec,
    output PrivLevel  priv,
    output logic      irqPending,
    output IrqCause   irqCause
);

    logic writeEn;
    CsrAddr writeAddr;
    CsrData writeData;
    logic mretEn;
    logic userCountOk;
    logic mstatusMie;
    CsrData mie;
    CsrData trapRegsRdata;
    logic trapRegsHit;
    CsrData counterRdata;
    logic counterHit;
    CsrData irqRdata;
    logic irqHit;

    csrControl control0 (.*);

    machineTrapRegs trapRegs0 (.*, .rdata(trapRegsRdata), .hit(trapRegsHit));

    perfCounters counters0 (.*, .rdata(counterRdata), .hit(counterHit));

    interruptArbiter irqArb0 (.*, .rdata(irqRdata), .hit(irqHit));

endmodule

//--- bench/csrVectors.svh
`ifndef CSR_VECTORS_SVH
`define CSR_VECTORS_SVH

// one row per request or trap
// trap rows: src holds the trap pc, expVal[3:0] the cause
typedef struct {
    string name;
    logic isTrap;
    CsrOp op;
    CsrAddr addr;
    logic rnd; // src (or trap value) comes from $random
    CsrData src;
    logic [4:0] imm;
    logic rd;
    CsrData expVal; // used for addresses without a shadow
    ResultFlag expFlag;
    PrivLevel expPriv;
} Step;

Step steps[$];

task automatic addStep(input string name, input logic isTrap, input CsrOp op, input CsrAddr addr,
        input logic rnd, input CsrData src, input logic [4:0] imm, input logic rd,
        input CsrData expVal, input ResultFlag expFlag, input PrivLevel expPriv);
    Step s;
    s = '{name, isTrap, op, addr, rnd, src, imm, rd, expVal, expFlag, expPriv};
    steps.push_back(s);
endtask

task automatic loadVectors();
    addStep("wr scratch", 0, OpWrite, `CSR_MSCRATCH, 1, 0, 0, 0, 0, FlagNone, PrivMachine);
    addStep("rd scratch", 0, OpRead, `CSR_MSCRATCH, 0, 0, 0, 1, 0, FlagNone, PrivMachine);
    addStep("set scratch", 0, OpSet, `CSR_MSCRATCH, 1, 0, 0, 1, 0, FlagNone, PrivMachine);
    addStep("clr scratch", 0, OpClear, `CSR_MSCRATCH, 1, 0, 0, 1, 0, FlagNone, PrivMachine);
    addStep("wri scratch", 0, OpWriteImm, `CSR_MSCRATCH, 0, 0, 5'h0b, 1, 0, FlagNone,
        PrivMachine);
    addStep("rd scratch2", 0, OpRead, `CSR_MSCRATCH, 0, 0, 0, 1, 0, FlagNone, PrivMachine);
    addStep("wr mtval", 0, OpWrite, `CSR_MTVAL, 1, 0, 0, 0, 0, FlagNone, PrivMachine);
    addStep("seti mtval", 0, OpSetImm, `CSR_MTVAL, 0, 0, 5'h15, 1, 0, FlagNone, PrivMachine);
    addStep("clri mtval", 0, OpClearImm, `CSR_MTVAL, 0, 0, 5'h03, 1, 0, FlagNone, PrivMachine);
    addStep("rd mtval", 0, OpRead, `CSR_MTVAL, 0, 0, 0, 1, 0, FlagNone, PrivMachine);
    addStep("wr hartid", 0, OpWrite, `CSR_MHARTID, 0, 1, 0, 1, 0, FlagIllegal, PrivMachine);
    addStep("rd hartid", 0, OpRead, `CSR_MHARTID, 0, 0, 0, 1, 0, FlagNone, PrivMachine);
    addStep("unknown", 0, OpRead, 12'h7c0, 0, 0, 0, 1, 0, FlagIllegal, PrivMachine);
    addStep("mpp user", 0, OpWrite, `CSR_MSTATUS, 0, 0, 0, 0, 0, FlagNone, PrivMachine);
    addStep("mret user", 0, OpMret, 0, 0, 0, 0, 0, 0, FlagXret, PrivUser);
    addStep("user scratch", 0, OpRead, `CSR_MSCRATCH, 0, 0, 0, 1, 0, FlagIllegal, PrivUser);
    addStep("user cycle off", 0, OpRead, `CSR_CYCLE, 0, 0, 0, 1, 0, FlagIllegal, PrivUser);
    addStep("trap ecall", 1, OpRead, 0, 1, 32'h100, 0, 0, 32'd2, FlagNone, PrivMachine);
    addStep("rd mepc", 0, OpRead, `CSR_MEPC, 0, 0, 0, 1, 32'h200, FlagNone, PrivMachine);
    addStep("rd mcause", 0, OpRead, `CSR_MCAUSE, 0, 0, 0, 1, 32'd2, FlagNone, PrivMachine);
    addStep("rd mtval trap", 0, OpRead, `CSR_MTVAL, 0, 0, 0, 1, 0, FlagNone, PrivMachine);
    addStep("counteren", 0, OpWrite, `CSR_MCOUNTEREN, 0, 1, 0, 0, 0, FlagNone, PrivMachine);
    addStep("mret back", 0, OpMret, 0, 0, 0, 0, 0, 0, FlagXret, PrivUser);
    addStep("user cycle on", 0, OpRead, `CSR_CYCLE, 0, 0, 0, 0, 0, FlagNone, PrivUser);
    addStep("trap again", 1, OpRead, 0, 1, 32'h180, 0, 0, 32'd2, FlagNone, PrivMachine);
endtask

`endif

//--- bench/csrUnitTb.sv
`timescale 1ns/1ps
`include "csr_config.svh"

module csrUnitTb import csrPkg::*; ();

    localparam int TimeoutCycles = 50;

    logic clk;
    logic rst;
    logic reqValid;
    CsrOp reqOp;
    CsrAddr reqAddr;
    CsrData reqSrc;
    logic [4:0] reqImm;
    logic reqReadDst;
    logic trapValid;
    CodeAddr trapPc;
    TrapCause trapCause;
    logic trapIsIrq;
    CsrData trapVal;
    logic irq;
    CounterVal mtime;
    CounterVal mtimecmp;
    logic [$clog2(`CSR_RETIRE_WIDTH + 1) - 1:0] retireCount;
    logic resultValid;
    CsrData result;
    ResultFlag resultFlag;
    CodeAddr retVec;
    CodeAddr trapVec;
    PrivLevel priv;
    logic irqPending;
    IrqCause irqCause;

    integer seed = 32'h8d42;
    int passCount = 0;
    int failCount = 0;
    CsrData scratchModel; // shadows of mscratch and mtval
    CsrData mtvalModel;
    CodeAddr lastTrapPc;

    `include "csrVectors.svh"

    csrUnit dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic checkData(input string name, input CsrData expected, input CsrData actual);
        if (actual === expected) begin
            passCount++;
            $display("ok %s", name);
        end else begin
            failCount++;
            $display("mismatch %s: expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic checkFlag(input string name, input ResultFlag expected, input ResultFlag actual);
        if (actual === expected) begin
            passCount++;
            $display("ok %s flag", name);
        end else begin
            failCount++;
            $display("mismatch %s flag: expected %s actual %s", name, expected.name(),
                actual.name());
        end
    endtask

    task automatic checkPriv(input string name, input PrivLevel expected, input PrivLevel actual);
        if (actual === expected) begin
            passCount++;
            $display("ok %s priv", name);
        end else begin
            failCount++;
            $display("mismatch %s priv: expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic checkCause(input string name, input IrqCause expected, input IrqCause actual);
        if (actual === expected) begin
            passCount++;
            $display("ok %s cause", name);
        end else begin
            failCount++;
            $display("mismatch %s cause: expected %0d actual %0d", name, expected, actual);
        end
    endtask

    function automatic CsrData applyOp(input CsrOp op, input CsrData old, input CsrData src,
            input logic [4:0] imm);
        CsrData val;
        val = (op == OpWriteImm || op == OpSetImm || op == OpClearImm) ? CsrData'(imm) : src;
        case (op)
            OpWrite, OpWriteImm: return val;
            OpSet, OpSetImm: return old | val;
            OpClear, OpClearImm: return old & ~val;
            default: return old;
        endcase
    endfunction

    task automatic doRequest(input string name, input CsrOp op, input CsrAddr addr,
            input CsrData src, input logic [4:0] imm, input logic rd,
            output CsrData res, output ResultFlag flg);
        int waited;
        @(posedge clk);
        #2;
        reqValid = 1'b1;
        reqOp = op;
        reqAddr = addr;
        reqSrc = src;
        reqImm = imm;
        reqReadDst = rd;
        @(posedge clk);
        #2;
        reqValid = 1'b0;
        waited = 0;
        while (!resultValid && waited < TimeoutCycles) begin
            @(negedge clk);
            waited++;
        end
        if (!resultValid) begin
            failCount++;
            $display("error: no result for %s within %0d cycles", name, TimeoutCycles);
        end
        res = result;
        flg = resultFlag;
    endtask

    // waits until irqPending reaches the wanted level, and the cause when pending
    task automatic waitIrq(input string name, input logic wantPending, input IrqCause cause);
        int waited;
        waited = 0;
        while (!(irqPending == wantPending && (!wantPending || irqCause == cause))
                && waited < TimeoutCycles) begin
            @(negedge clk);
            waited++;
        end
        if (irqPending !== wantPending) begin
            failCount++;
            $display("error: irqPending for %s never became %b", name, wantPending);
        end else begin
            passCount++;
            $display("ok %s pending", name);
            if (wantPending)
                checkCause(name, cause, irqCause);
        end
    endtask

    task automatic runTable();
        CsrData res;
        ResultFlag flg;
        CsrData src;
        CsrData expRes;
        logic trapSeen;
        trapSeen = 1'b0;
        foreach (steps[i]) begin
            src = steps[i].rnd ? CsrData'($random(seed)) : steps[i].src;
            if (steps[i].isTrap) begin
                @(posedge clk);
                #2;
                trapValid = 1'b1;
                trapPc = steps[i].src[30:0];
                trapCause = steps[i].expVal[3:0];
                trapVal = src;
                @(posedge clk);
                #2;
                trapValid = 1'b0;
                lastTrapPc = steps[i].src[30:0];
                mtvalModel = src;
                trapSeen = 1'b1;
                // mtvec is never written, so traps go to the reset entry point
                checkData({steps[i].name, " trapVec"}, `CSR_ENTRY_POINT, {trapVec, 1'b0});
            end else begin
                doRequest(steps[i].name, steps[i].op, steps[i].addr, src, steps[i].imm,
                    steps[i].rd, res, flg);
                if (steps[i].expFlag == FlagIllegal || !steps[i].rd || steps[i].op == OpMret)
                    expRes = '0;
                else if (steps[i].addr == `CSR_MSCRATCH)
                    expRes = scratchModel;
                else if (steps[i].addr == `CSR_MTVAL)
                    expRes = mtvalModel;
                else
                    expRes = steps[i].expVal;
                checkData(steps[i].name, expRes, res);
                checkFlag(steps[i].name, steps[i].expFlag, flg);
                if (steps[i].expFlag == FlagNone && steps[i].addr == `CSR_MSCRATCH)
                    scratchModel = applyOp(steps[i].op, scratchModel, src, steps[i].imm);
                if (steps[i].expFlag == FlagNone && steps[i].addr == `CSR_MTVAL)
                    mtvalModel = applyOp(steps[i].op, mtvalModel, src, steps[i].imm);
                if (steps[i].op == OpMret && trapSeen) // mepc only known after a trap
                    checkData({steps[i].name, " retVec"}, {lastTrapPc, 1'b0}, {retVec, 1'b0});
            end
            checkPriv(steps[i].name, steps[i].expPriv, priv);
        end
    endtask

    task automatic runInterrupts();
        CsrData res;
        ResultFlag flg;
        doRequest("mie on", OpWrite, `CSR_MIE, 32'h0000_0880, 0, 0, res, flg);
        doRequest("mstatus mie", OpWrite, `CSR_MSTATUS, 32'h0000_0008, 0, 0, res, flg);
        @(posedge clk);
        #2;
        mtimecmp = 64'd50; // below mtime
        waitIrq("timer irq", 1'b1, IrqMti);
        @(posedge clk);
        #2;
        irq = 1'b1;
        waitIrq("external irq", 1'b1, IrqMei);
        doRequest("mstatus off", OpWrite, `CSR_MSTATUS, 32'h0, 0, 0, res, flg);
        waitIrq("irq masked", 1'b0, IrqMei);
        @(posedge clk);
        #2;
        irq = 1'b0;
        mtimecmp = '1;
    endtask

    task automatic runCounters();
        CsrData res;
        CsrData first;
        ResultFlag flg;
        int sum;
        int retireSeq[7] = '{1, 2, 0, 2, 1, 2, 2};
        doRequest("inhibit instret", OpWrite, `CSR_MCOUNTINHIBIT, 32'h4, 0, 0, res, flg);
        doRequest("clear minstret", OpWrite, `CSR_MINSTRET, 32'h0, 0, 0, res, flg);
        doRequest("count instret", OpWrite, `CSR_MCOUNTINHIBIT, 32'h0, 0, 0, res, flg);
        sum = 0;
        foreach (retireSeq[i]) begin
            @(posedge clk);
            #2;
            retireCount = retireSeq[i][1:0];
            sum += retireSeq[i];
        end
        @(posedge clk);
        #2;
        retireCount = '0;
        doRequest("rd minstret", OpRead, `CSR_MINSTRET, 0, 0, 1, res, flg);
        checkData("rd minstret", CsrData'(sum), res);
        doRequest("inhibit cycle", OpWrite, `CSR_MCOUNTINHIBIT, 32'h1, 0, 0, res, flg);
        doRequest("rd mcycle", OpRead, `CSR_MCYCLE, 0, 0, 1, first, flg);
        doRequest("rd mcycle again", OpRead, `CSR_MCYCLE, 0, 0, 1, res, flg);
        checkData("mcycle frozen", first, res);
    endtask

    initial begin
        rst = 1'b1;
        reqValid = 1'b0;
        reqOp = OpRead;
        reqAddr = '0;
        reqSrc = '0;
        reqImm = '0;
        reqReadDst = 1'b0;
        trapValid = 1'b0;
        trapPc = '0;
        trapCause = '0;
        trapIsIrq = 1'b0;
        trapVal = '0;
        irq = 1'b0;
        mtime = 64'd100;
        mtimecmp = '1;
        retireCount = '0;
        scratchModel = '0;
        mtvalModel = '0;
        lastTrapPc = '0;
        loadVectors();
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        runTable();
        runInterrupts();
        runCounters();
        $display("checks passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+source
+incdir+bench
source/csrPkg.sv
source/csrControl.sv
source/machineTrapRegs.sv
source/perfCounters.sv
source/interruptArbiter.sv
source/csrUnit.sv
bench/csrUnitTb.sv

//--- run.sh
#!/bin/sh
# build and run the csrUnit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module csrUnitTb \
    -o csrUnitTbSim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/csrUnitTbSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "no final status in log"
    exit 1
fi
exit 0
